// ==== build.f ====
+incdir+include
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_lru.sv
rtl/refill_counter.sv
rtl/icache_lookup.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/axi_mem_model.sv
verif/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_way_ram.sv
      - rtl/icache_lru.sv
      - rtl/refill_counter.sv
      - rtl/icache_lookup.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/axi_mem_model.sv
      - verif/tb_icache.sv

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_icache;

    localparam int NUM_FETCHES     = 400;
    localparam int MAX_GAP         = 3;
    localparam int WATCHDOG_CYCLES = (NUM_FETCHES + 10) * (2 + 16 * MAX_GAP + 4);

    logic clk, rst, fetch_en, stall_f, fence_i;
    logic [31:0] pc, pc_next, fence_addr;
    logic [31:0] inst_rdata0, inst_rdata1, araddr, rdata;
    logic inst_ok0, inst_ok1, istall, arvalid, arready, rlast, rvalid, rready;
    logic [7:0] arlen;
    logic [2:0] arsize;

    // reference cache state
    logic [`ICACHE_TAG_BITS-1:0] m_tag   [`ICACHE_SETS][2];
    logic                        m_valid [`ICACHE_SETS][2];
    logic                        m_lru   [`ICACHE_SETS];

    integer      seed;
    logic [31:0] r, cur_pc, next_pc;
    int          way, fetched, misses, evictions, fences;
    logic        do_fence, accept;

    icache_top icache_top_i (.*);

    axi_mem_model #(.MAX_GAP(MAX_GAP), .SEED(32'h0dfec8c4)) mem_i (
        .clk(clk), .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] k;
        int          rot;
        k   = 32'h9e3779b9;
        rot = a[6:2];
        return a ^ ((k << rot) | (k >> (32 - rot)));
    endfunction

    function automatic logic [`ICACHE_INDEX_BITS-1:0] idx_of(input logic [31:0] a);
        return a[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS];
    endfunction

    // three tags over two sets overflow the two ways
    function automatic logic [31:0] make_pc(input logic [31:0] rnd);
        logic [19:0] tag;
        case (rnd[1:0])
            2'd0:    tag = 20'h0a5c0;
            2'd1:    tag = 20'h13371;
            default: tag = 20'h2f0e2;
        endcase
        return {tag, (rnd[2] ? 6'd17 : 6'd42), rnd[7:4], 2'b00};
    endfunction

    function automatic int model_way(input logic [31:0] a);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx_of(a)][w] && m_tag[idx_of(a)][w] == a[31 -: `ICACHE_TAG_BITS]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopped on mismatch of %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // walks the DUT through AR, the data beats and the reread
    task automatic follow_refill(input logic [31:0] a);
        logic victim;
        victim = m_lru[idx_of(a)];
        next_cycle();
        stall_f = $random(seed) & 1;
        @(negedge clk);
        expect_equal("arvalid", arvalid, 1);
        expect_equal("araddr", araddr, {a[31:6], 6'b0});
        expect_equal("arlen", arlen, 15);
        expect_equal("arsize", arsize, 2);
        expect_equal("istall", istall, 1);
        expect_equal("rready", rready, 0);
        while (!arready) begin
            expect_equal("istall", istall, 1);
            next_cycle();
            @(negedge clk);
            expect_equal("arvalid", arvalid, 1);
        end
        next_cycle();
        @(negedge clk);
        while (!(rvalid && rlast)) begin
            expect_equal("rready", rready, 1);
            expect_equal("arvalid", arvalid, 0);
            expect_equal("istall", istall, 1);
            next_cycle();
            @(negedge clk);
        end
        expect_equal("rready", rready, 1);
        next_cycle();
        @(negedge clk);
        expect_equal("rready", rready, 0);
        expect_equal("arvalid", arvalid, 0);
        expect_equal("istall", istall, 1);
        expect_equal("inst_ok0", inst_ok0, 0);
        if (m_valid[idx_of(a)][victim]) begin
            evictions++;
        end
        m_tag[idx_of(a)][victim]   = a[31 -: `ICACHE_TAG_BITS];
        m_valid[idx_of(a)][victim] = 1'b1;
        misses++;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d fetches done",
                 WATCHDOG_CYCLES, fetched);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed       = 32'h0dfec8c4;
        rst        = 1'b1;
        fetch_en   = 1'b0;
        stall_f    = 1'b0;
        fence_i    = 1'b0;
        fence_addr = '0;
        pc         = '0;
        pc_next    = '0;
        fetched    = 0;
        misses     = 0;
        evictions  = 0;
        fences     = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst     = 1'b0;
        cur_pc  = make_pc($random(seed));
        pc      = cur_pc;
        pc_next = cur_pc;
        repeat (2) begin
            @(negedge clk);
            expect_equal("arvalid", arvalid, 0);
            expect_equal("rready", rready, 0);
            expect_equal("istall", istall, 0);
            expect_equal("inst_ok0", inst_ok0, 0);
            next_cycle();
        end
        while (fetched < NUM_FETCHES) begin
            r          = $random(seed);
            next_pc    = make_pc($random(seed));
            way        = model_way(cur_pc);
            do_fence   = (r[3:0] == 4'd0);
            fetch_en   = 1'b1;
            pc         = cur_pc;
            stall_f    = (r[5:4] == 2'b00);
            fence_i    = do_fence;
            fence_addr = make_pc($random(seed));
            accept     = !do_fence && way >= 0 && !stall_f;
            pc_next    = accept ? next_pc : cur_pc;
            @(negedge clk);
            expect_equal("arvalid", arvalid, 0);
            expect_equal("istall", istall, 0);
            if (do_fence) begin
                expect_equal("inst_ok0", inst_ok0, 0);
                expect_equal("inst_ok1", inst_ok1, 0);
                next_cycle();
                fence_i = 1'b0;
                @(negedge clk);
                expect_equal("inst_ok0", inst_ok0, 0);
                expect_equal("istall", istall, 0);
                m_valid[idx_of(fence_addr)][0] = 1'b0;
                m_valid[idx_of(fence_addr)][1] = 1'b0;
                fences++;
            end else if (way < 0) begin
                expect_equal("inst_ok0", inst_ok0, 0);
                expect_equal("inst_ok1", inst_ok1, 0);
                follow_refill(cur_pc);
            end else begin
                expect_equal("inst_ok0", inst_ok0, 1);
                expect_equal("inst_rdata0", inst_rdata0, mem_word(cur_pc));
                expect_equal("inst_ok1", inst_ok1, !cur_pc[2]);
                if (!cur_pc[2]) begin
                    expect_equal("inst_rdata1", inst_rdata1, mem_word(cur_pc + 32'd4));
                end
                if (accept) begin
                    m_lru[idx_of(cur_pc)] = (way == 0);
                    cur_pc = next_pc;
                    fetched++;
                end
            end
            next_cycle();
        end
        if (misses == 0 || evictions == 0 || fences == 0) begin
            $display("random stimulus produced %0d refills, %0d evictions, %0d fences",
                     misses, evictions, fences);
            $display(">>> FAIL");
            $fatal(1, "stimulus missed a required case");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          MAX_GAP = 3,
    parameter logic [31:0] SEED    = 32'h0dfec8c4
) (
    input  logic         clk,
    input  logic [31:0]  araddr,
    input  logic [7:0]   arlen,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic         rlast,
    output logic         rvalid,
    input  logic         rready
);

    integer      seed;
    logic [31:0] addr;
    int          beats_left;
    int          gap;
    logic        ar_fire;
    logic        r_fire;

    // word(addr) = addr xor a constant rotated by the word bits of addr
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] k;
        int          rot;
        k   = 32'h9e3779b9;
        rot = a[6:2];
        return a ^ ((k << rot) | (k >> (32 - rot)));
    endfunction

    initial begin
        seed       = SEED;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;
        addr       = '0;
        beats_left = 0;
        gap        = 0;
        forever begin
            @(negedge clk);
            ar_fire = arvalid & arready;
            r_fire  = rvalid & rready;
            @(posedge clk);
            #1;
            if (ar_fire) begin
                addr       = araddr;
                beats_left = arlen + 1;
                gap        = 0;
            end
            if (r_fire) begin
                addr       = addr + 32'd4;
                beats_left = beats_left - 1;
                gap        = 0;
            end
            arready = 1'b0;
            if (beats_left == 0) begin
                rvalid  = 1'b0;
                rlast   = 1'b0;
                arready = (gap >= MAX_GAP) || ($random(seed) & 1);
                gap     = arready ? 0 : gap + 1;
            end else if (!rvalid || r_fire) begin
                // a beat that is offered stays until taken
                rvalid = (gap >= MAX_GAP) || ($random(seed) & 1);
                gap    = rvalid ? 0 : gap + 1;
                rdata  = mem_word(addr);
                rlast  = (beats_left == 1);
            end
        end
    end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetch_en,
    input  logic [31:0]  pc,
    input  logic [31:0]  pc_next,
    input  logic         stall_f,
    input  logic         fence_i,
    input  logic [31:0]  fence_addr,
    output logic [31:0]  inst_rdata0,
    output logic [31:0]  inst_rdata1,
    output logic         inst_ok0,
    output logic         inst_ok1,
    output logic         istall,
    output logic [31:0]  araddr,
    output logic [7:0]   arlen,
    output logic [2:0]   arsize,
    output logic         arvalid,
    input  logic         arready,
    input  logic [31:0]  rdata,
    input  logic         rlast,
    input  logic         rvalid,
    output logic         rready
);

    logic                          hit;
    logic                          hit_way;
    logic                          victim_way;
    logic                          hit_accept;
    logic                          rd_sel_pc;
    logic                          cnt_start;
    logic                          beat;
    logic [`ICACHE_WORD_BITS-1:0]  wr_word;
    logic [1:0]                    half_we;
    logic [1:0]                    data_we0;
    logic [1:0]                    data_we1;
    logic                          tag_we0;
    logic                          tag_we1;
    logic [`ICACHE_INDEX_BITS-1:0] wr_line;
    icache_pkg::tag_entry_t        tag_wdata;
    logic                          set_valid;
    logic [31:0]                   rd_pc;
    logic [63:0]                   way0_data;
    logic [63:0]                   way1_data;
    icache_pkg::tag_entry_t        way0_tag;
    icache_pkg::tag_entry_t        way1_tag;

    // pc_next in IDLE so the lookup lines up with pc
    assign rd_pc = rd_sel_pc ? pc : pc_next;

    icache_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .pc         (pc),
        .stall_f    (stall_f),
        .fence_i    (fence_i),
        .fence_addr (fence_addr),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .arready    (arready),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arvalid    (arvalid),
        .rready     (rready),
        .inst_ok0   (inst_ok0),
        .inst_ok1   (inst_ok1),
        .istall     (istall),
        .hit_accept (hit_accept),
        .rd_sel_pc  (rd_sel_pc),
        .cnt_start  (cnt_start),
        .beat       (beat),
        .half_we    (half_we),
        .data_we0   (data_we0),
        .data_we1   (data_we1),
        .tag_we0    (tag_we0),
        .tag_we1    (tag_we1),
        .wr_line    (wr_line),
        .tag_wdata  (tag_wdata),
        .set_valid  (set_valid)
    );

    refill_counter cnt_i (
        .clk     (clk),
        .rst     (rst),
        .start   (cnt_start),
        .beat    (beat),
        .word    (wr_word),
        .half_we (half_we)
    );

    icache_lru lru_i (
        .clk        (clk),
        .rst        (rst),
        .index      (pc[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS]),
        .hit_accept (hit_accept),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_lookup lookup_i (
        .pc        (pc),
        .way0_tag  (way0_tag),
        .way1_tag  (way1_tag),
        .way0_data (way0_data),
        .way1_data (way1_data),
        .set_valid (set_valid),
        .hit       (hit),
        .hit_way   (hit_way),
        .pair0     (inst_rdata0),
        .pair1     (inst_rdata1)
    );

    icache_way_ram way0_i (
        .clk       (clk),
        .wr_line   (wr_line),
        .wr_word   (wr_word),
        .data_we   (data_we0),
        .wr_data   (rdata),
        .tag_we    (tag_we0),
        .tag_wdata (tag_wdata),
        .rd_line   (rd_pc[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS]),
        .rd_word   (rd_pc[3 +: `ICACHE_WORD_BITS]),
        .rd_data   (way0_data),
        .rd_tag    (way0_tag)
    );

    icache_way_ram way1_i (
        .clk       (clk),
        .wr_line   (wr_line),
        .wr_word   (wr_word),
        .data_we   (data_we1),
        .wr_data   (rdata),
        .tag_we    (tag_we1),
        .tag_wdata (tag_wdata),
        .rd_line   (rd_pc[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS]),
        .rd_word   (rd_pc[3 +: `ICACHE_WORD_BITS]),
        .rd_data   (way1_data),
        .rd_tag    (way1_tag)
    );

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_en,
    input  logic [31:0]                    pc,
    input  logic                           stall_f,
    input  logic                           fence_i,
    input  logic [31:0]                    fence_addr,
    input  logic                           hit,
    input  logic                           hit_way,
    input  logic                           victim_way,
    input  logic                           arready,
    input  logic                           rvalid,
    input  logic                           rlast,
    output logic [31:0]                    araddr,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic                           arvalid,
    output logic                           rready,
    output logic                           inst_ok0,
    output logic                           inst_ok1,
    output logic                           istall,
    output logic                           hit_accept,
    output logic                           rd_sel_pc,
    output logic                           cnt_start,
    output logic                           beat,
    input  logic [1:0]                     half_we,
    output logic [1:0]                     data_we0,
    output logic [1:0]                     data_we1,
    output logic                           tag_we0,
    output logic                           tag_we1,
    output logic [`ICACHE_INDEX_BITS-1:0]  wr_line,
    output icache_pkg::tag_entry_t         tag_wdata,
    output logic                           set_valid
);

    icache_pkg::icache_state_e state;

    logic [`ICACHE_INDEX_BITS-1:0] line_q;
    logic                          victim_q;
    logic [`ICACHE_SETS-1:0]       valid_vec;
    logic                          idle;
    logic                          miss;
    logic                          fence_wr;
    logic                          clr_wr;
    logic                          fill_wr;

    assign idle = (state == icache_pkg::IDLE);
    assign miss = idle & fetch_en & ~fence_i & ~hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::IDLE;
        end else begin
            case (state)
                icache_pkg::IDLE: begin
                    if (fence_i) begin
                        state <= icache_pkg::FENCE;
                    end else if (miss) begin
                        state <= icache_pkg::REFILL_REQ;
                    end
                end
                icache_pkg::FENCE: begin
                    state <= icache_pkg::IDLE;
                end
                icache_pkg::REFILL_REQ: begin
                    if (arready) begin
                        state <= icache_pkg::REFILL_DATA;
                    end
                end
                icache_pkg::REFILL_DATA: begin
                    if (rvalid && rlast) begin
                        state <= icache_pkg::REREAD;
                    end
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // target set and victim are captured when leaving IDLE
    always_ff @(posedge clk) begin
        if (idle && fence_i) begin
            line_q <= fence_addr[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS];
        end else if (miss) begin
            line_q   <= pc[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS];
            victim_q <= victim_way;
        end
    end

    // per-set valid flags, so tag RAM needs no sweep on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_vec <= '0;
        end else if (fence_wr) begin
            valid_vec[line_q] <= 1'b0;
        end else if (fill_wr) begin
            valid_vec[line_q] <= 1'b1;
        end
    end

    assign set_valid = valid_vec[pc[`ICACHE_LINE_BITS +: `ICACHE_INDEX_BITS]];

    // CPU side
    assign inst_ok0   = idle & fetch_en & ~fence_i & hit;
    assign inst_ok1   = inst_ok0 & ~pc[2];
    assign hit_accept = inst_ok0 & ~stall_f;
    assign istall     = (state == icache_pkg::REFILL_REQ) |
                        (state == icache_pkg::REFILL_DATA) |
                        (state == icache_pkg::REREAD);
    assign rd_sel_pc  = ~idle;

    // AXI read burst
    assign araddr  = {pc[31:`ICACHE_LINE_BITS], {`ICACHE_LINE_BITS{1'b0}}};
    assign arlen   = 8'(`ICACHE_BURST_WORDS - 1);
    assign arsize  = 3'd2;
    assign arvalid = (state == icache_pkg::REFILL_REQ);
    assign rready  = (state == icache_pkg::REFILL_DATA);

    assign cnt_start = miss;
    assign beat      = rready & rvalid;

    assign data_we0 = (beat && !victim_q) ? half_we : 2'b00;
    assign data_we1 = (beat && victim_q) ? half_we : 2'b00;

    // first fill of an unused set invalidates the other way's tag too
    assign fence_wr = (state == icache_pkg::FENCE);
    assign clr_wr   = (state == icache_pkg::REFILL_REQ) & ~valid_vec[line_q];
    assign fill_wr  = beat & rlast;

    assign tag_we0 = fence_wr | clr_wr | (fill_wr & ~victim_q);
    assign tag_we1 = fence_wr | clr_wr | (fill_wr & victim_q);

    assign wr_line         = line_q;
    assign tag_wdata.valid = fill_wr;
    assign tag_wdata.tag   = fill_wr ? pc[31 -: `ICACHE_TAG_BITS] : '0;

endmodule

// ==== rtl/icache_lookup.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_lookup (
    input  logic [31:0]             pc,
    input  icache_pkg::tag_entry_t  way0_tag,
    input  icache_pkg::tag_entry_t  way1_tag,
    input  logic [63:0]             way0_data,
    input  logic [63:0]             way1_data,
    input  logic                    set_valid,
    output logic                    hit,
    output logic                    hit_way,
    output logic [31:0]             pair0,
    output logic [31:0]             pair1
);

    logic [`ICACHE_TAG_BITS-1:0] pc_tag;
    logic [`ICACHE_WAYS-1:0]     way_hit;
    logic [63:0]                 sel_data;

    assign pc_tag = pc[31 -: `ICACHE_TAG_BITS];

    // set_valid masks stale tags after reset or fence
    assign way_hit[0] = set_valid & way0_tag.valid & (way0_tag.tag == pc_tag);
    assign way_hit[1] = set_valid & way1_tag.valid & (way1_tag.tag == pc_tag);

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign sel_data = hit_way ? way1_data : way0_data;

    // pc bit 2 picks which half is the first instruction
    assign pair0 = pc[2] ? sel_data[63:32] : sel_data[31:0];
    assign pair1 = sel_data[63:32];

endmodule

// ==== rtl/refill_counter.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module refill_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          beat,
    output logic [`ICACHE_WORD_BITS-1:0]  word,
    output logic [1:0]                    half_we
);

    localparam int CNT_BITS = $clog2(`ICACHE_BURST_WORDS);

    logic [CNT_BITS-1:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // even beats go to the low half, odd beats to the high half
    assign word    = beat_cnt[CNT_BITS-1:1];
    assign half_we = beat_cnt[0] ? 2'b10 : 2'b01;

endmodule

// ==== rtl/icache_lru.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_lru (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`ICACHE_INDEX_BITS-1:0]  index,
    input  logic                           hit_accept,
    input  logic                           hit_way,
    output logic                           victim_way
);

    // bit set means way 1 is the next victim
    logic [`ICACHE_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (hit_accept) begin
            lru_bits[index] <= ~hit_way;
        end
    end

    assign victim_way = lru_bits[index];

endmodule

// ==== rtl/icache_way_ram.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_way_ram (
    input  logic                           clk,
    input  logic [`ICACHE_INDEX_BITS-1:0]  wr_line,
    input  logic [`ICACHE_WORD_BITS-1:0]   wr_word,
    input  logic [1:0]                     data_we,
    input  logic [31:0]                    wr_data,
    input  logic                           tag_we,
    input  icache_pkg::tag_entry_t         tag_wdata,
    input  logic [`ICACHE_INDEX_BITS-1:0]  rd_line,
    input  logic [`ICACHE_WORD_BITS-1:0]   rd_word,
    output logic [63:0]                    rd_data,
    output icache_pkg::tag_entry_t         rd_tag
);

    localparam int DEPTH = `ICACHE_SETS << `ICACHE_WORD_BITS;

    logic [63:0]            data_mem [DEPTH];
    icache_pkg::tag_entry_t tag_mem  [`ICACHE_SETS];

    logic [`ICACHE_INDEX_BITS+`ICACHE_WORD_BITS-1:0] wr_addr;
    logic [`ICACHE_INDEX_BITS+`ICACHE_WORD_BITS-1:0] rd_addr;

    assign wr_addr = {wr_line, wr_word};
    assign rd_addr = {rd_line, rd_word};

    // each beat fills one half of a double-word
    always_ff @(posedge clk) begin
        if (data_we[0]) begin
            data_mem[wr_addr][31:0] <= wr_data;
        end
        if (data_we[1]) begin
            data_mem[wr_addr][63:32] <= wr_data;
        end
        rd_data <= data_mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_line] <= tag_wdata;
        end
        rd_tag <= tag_mem[rd_line];
    end

endmodule

// ==== rtl/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        FENCE,
        REFILL_REQ,
        REFILL_DATA,
        REREAD
    } icache_state_e;

    // one tag RAM entry
    typedef struct packed {
        logic                         valid;
        logic [`ICACHE_TAG_BITS-1:0]  tag;
    } tag_entry_t;

endpackage

// ==== include/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// byte offset within a 64-byte line
`define ICACHE_LINE_BITS 6

// 64 sets
`define ICACHE_INDEX_BITS 6

`define ICACHE_TAG_BITS (32 - `ICACHE_LINE_BITS - `ICACHE_INDEX_BITS)

// double-word position within a line
`define ICACHE_WORD_BITS (`ICACHE_LINE_BITS - 3)

`define ICACHE_SETS (1 << `ICACHE_INDEX_BITS)

// fixed at two, the LRU keeps one bit per set
`define ICACHE_WAYS 2

// 32-bit beats per line refill
`define ICACHE_BURST_WORDS 16

`endif
